//--- run_sim.sh
#!/bin/sh
# build and run the mem_subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f sim.f --top-module tb_mem_subsystem \
  -o tb_mem_subsystem > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/tb_mem_subsystem > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "FAIL: see errors above" sim.log; then
  exit 1
fi
exit 0

//--- sim.f
src/mem_pkg.sv
src/sync_fifo.sv
src/client_port.sv
src/req_arbiter.sv
src/resp_router.sv
src/mem_subsystem.sv
sim/mem_model.sv
sim/tb_mem_subsystem.sv

//--- sim/mem_model.sv
/*
 * Behavioural memory for the testbench: word storage, in-order
 * responses 3 cycles after each request, one credit per response
 * and a stall input that holds credits back.
 */

module mem_model (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        req_valid_i,
  input  logic                        req_we_i,
  input  logic [mem_pkg::ADDR_W-1:0]  req_addr_i,
  input  logic [mem_pkg::DATA_W-1:0]  req_wdata_i,
  input  logic [mem_pkg::ID_W-1:0]    req_id_i,
  input  logic                        stall_i,
  output logic                        credit_o,
  output logic                        rsp_valid_o,
  output logic [mem_pkg::ID_W-1:0]    rsp_id_o,
  output logic [mem_pkg::DATA_W-1:0]  rsp_rdata_o
);

  logic [mem_pkg::DATA_W-1:0]  store [2**mem_pkg::ADDR_W];
  mem_pkg::rsp_t               rsp_in;
  mem_pkg::rsp_t               rsp_out;
  logic [2:0]                  dly_q;
  logic [2:0]                  owed_q;
  logic [2:0]                  owed;

  // write responses carry zero
  assign rsp_in = '{id: req_id_i, rdata: (req_we_i ? '0 : store[req_addr_i])};

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_we_i) begin
      store[req_addr_i] <= req_wdata_i;
    end
  end

  // response waits in the FIFO, the shift register times its release
  sync_fifo #(
    .payload_t (mem_pkg::rsp_t),
    .DEPTH     (mem_pkg::MEM_CREDITS)
  ) i_rsp_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (req_valid_i),
    .data_i  (rsp_in),
    .pop_i   (dly_q[2]),
    .data_o  (rsp_out),
    .empty_o (),
    .full_o  ()
  );

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dly_q  <= '0;
      owed_q <= '0;
    end else begin
      dly_q  <= {dly_q[1:0], req_valid_i};
      owed_q <= owed - {2'b00, credit_o};
    end
  end

  assign rsp_valid_o = dly_q[2];
  assign rsp_id_o    = rsp_out.id;
  assign rsp_rdata_o = rsp_out.rdata;

  // credits owed pile up while stalled, one goes back per cycle
  assign owed     = owed_q + {2'b00, dly_q[2]};
  assign credit_o = !stall_i && (owed != '0);

endmodule

//--- sim/tb_mem_subsystem.sv
/*
 * Testbench for mem_subsystem: clock, reset, memory model, stimulus
 * table applied in rounds of one request per client, and a monitor
 * for responses, arbitration order and credits.
 */

module tb_mem_subsystem;

  localparam int NC   = mem_pkg::NUM_CLIENTS;
  localparam int ROWS = 15;

  // ----------------------------------------------------------
  // stimulus table, row r belongs to round r / NC
  // ----------------------------------------------------------
  localparam int          TBL_CLI  [ROWS] = '{0, 1, 2, 0, 1, 2, 0, 1, 2, 0, 1, 2, 0, 1, 2};
  localparam bit          TBL_WE   [ROWS] = '{1, 1, 1, 0, 0, 0, 1, 0, 1, 0, 0, 1, 0, 1, 0};
  localparam logic [15:0] TBL_ADDR [ROWS] = '{
    16'h0010, 16'h0020, 16'h0030, 16'h0020, 16'h0030, 16'h0010, 16'h0030, 16'h0010,
    16'h0020, 16'h0020, 16'h0030, 16'h0010, 16'h0010, 16'h0040, 16'h0040
  };

  logic [mem_pkg::DATA_W-1:0]  tbl_wdata [ROWS];
  logic [mem_pkg::DATA_W-1:0]  tbl_exp [ROWS];
  logic [mem_pkg::DATA_W-1:0]  ref_mem [logic [15:0]];
  // expected tag and data per client, in issue order
  logic [mem_pkg::SEQ_W+mem_pkg::DATA_W-1:0] exp_q [NC][$];
  // expected bus tag, write flag, address and write data per client
  logic [mem_pkg::SEQ_W+mem_pkg::ADDR_W+mem_pkg::DATA_W:0] bus_q [NC][$];

  logic                        clk;
  logic                        rst_n;
  logic                        stall;
  logic [NC-1:0]               req_valid;
  logic [NC-1:0]               req_we;
  logic [mem_pkg::ADDR_W-1:0]  req_addr [NC];
  logic [mem_pkg::DATA_W-1:0]  req_wdata [NC];
  logic [NC-1:0]               credit;
  logic [NC-1:0]               rsp_valid;
  logic [mem_pkg::SEQ_W-1:0]   rsp_tag [NC];
  logic [mem_pkg::DATA_W-1:0]  rsp_rdata [NC];
  logic                        mem_req_valid;
  logic                        mem_req_we;
  logic [mem_pkg::ADDR_W-1:0]  mem_req_addr;
  logic [mem_pkg::DATA_W-1:0]  mem_req_wdata;
  logic [mem_pkg::ID_W-1:0]    mem_req_id;
  logic                        mem_credit;
  logic                        mem_rsp_valid;
  logic [mem_pkg::ID_W-1:0]    mem_rsp_id;
  logic [mem_pkg::DATA_W-1:0]  mem_rsp_rdata;

  int     cli_crd [NC];
  int     sent [NC];
  int     pulses [NC];
  int     mem_crd;
  int     req_seen;
  int     stall_reqs;
  int     errors;
  int     err_mark;
  int     tests_run;
  int     tests_failed;
  integer seed;

  mem_subsystem dut (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .cli_req_valid_i (req_valid),
    .cli_req_we_i    (req_we),
    .cli_req_addr_i  (req_addr),
    .cli_req_wdata_i (req_wdata),
    .cli_credit_o    (credit),
    .cli_rsp_valid_o (rsp_valid),
    .cli_rsp_tag_o   (rsp_tag),
    .cli_rsp_rdata_o (rsp_rdata),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_we_o    (mem_req_we),
    .mem_req_addr_o  (mem_req_addr),
    .mem_req_wdata_o (mem_req_wdata),
    .mem_req_id_o    (mem_req_id),
    .mem_credit_i    (mem_credit),
    .mem_rsp_valid_i (mem_rsp_valid),
    .mem_rsp_id_i    (mem_rsp_id),
    .mem_rsp_rdata_i (mem_rsp_rdata)
  );

  mem_model i_mem_model (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .req_valid_i (mem_req_valid),
    .req_we_i    (mem_req_we),
    .req_addr_i  (mem_req_addr),
    .req_wdata_i (mem_req_wdata),
    .req_id_i    (mem_req_id),
    .stall_i     (stall),
    .credit_o    (mem_credit),
    .rsp_valid_o (mem_rsp_valid),
    .rsp_id_o    (mem_rsp_id),
    .rsp_rdata_o (mem_rsp_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ----------------------------------------------------------
  // helpers
  // ----------------------------------------------------------
  task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %0h expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors != err_mark) begin
      tests_failed++;
    end
    $display("test %-14s %s", name, (errors == err_mark) ? "ok" : "failed");
    err_mark = errors;
  endtask

  // write data is random, reads expect the last value written
  task automatic build_table();
    for (int i = 0; i < ROWS; i++) begin
      tbl_wdata[i] = $random(seed);
      if (TBL_WE[i]) begin
        ref_mem[TBL_ADDR[i]] = tbl_wdata[i];
        tbl_exp[i] = '0;
      end else begin
        tbl_exp[i] = ref_mem[TBL_ADDR[i]];
      end
    end
  endtask

  function automatic bit have_credits();
    have_credits = 1'b1;
    for (int c = 0; c < NC; c++) begin
      have_credits &= (cli_crd[c] > 0);
    end
  endfunction

  function automatic bit is_idle();
    is_idle = (mem_crd == mem_pkg::MEM_CREDITS);
    for (int c = 0; c < NC; c++) begin
      is_idle &= (exp_q[c].size() == 0) && (cli_crd[c] == mem_pkg::CLI_DEPTH);
    end
  endfunction

  // one table row per client in the same cycle
  task automatic drive_round(input int r);
    int n;
    int row;
    int c;
    for (n = 0; n < 100 && !have_credits(); n++) begin
      @(negedge clk);
    end
    if (n == 100) begin
      $display("timeout: client credits did not come back before round %0d", r);
      errors++;
    end
    for (int k = 0; k < NC; k++) begin
      row = r * NC + k;
      c = TBL_CLI[row];
      req_valid[c] = 1'b1;
      req_we[c]    = TBL_WE[row];
      req_addr[c]  = TBL_ADDR[row];
      req_wdata[c] = tbl_wdata[row];
      exp_q[c].push_back({mem_pkg::SEQ_W'(sent[c]), tbl_exp[row]});
      bus_q[c].push_back({mem_pkg::SEQ_W'(sent[c]), TBL_WE[row], TBL_ADDR[row],
                          tbl_wdata[row]});
      sent[c]++;
      cli_crd[c]--;
    end
    @(negedge clk);
    req_valid = '0;
  endtask

  task automatic wait_idle(input string what);
    int n;
    for (n = 0; n < 200 && !is_idle(); n++) begin
      @(negedge clk);
    end
    if (n == 200) begin
      $display("timeout: %s did not complete", what);
      errors++;
    end
  endtask

  // ----------------------------------------------------------
  // monitor, samples the values settled before each rising edge
  // ----------------------------------------------------------
  always @(posedge clk) begin
    if (rst_n) begin
      for (int c = 0; c < NC; c++) begin
        if (credit[c]) begin
          cli_crd[c]++;
          pulses[c]++;
          if (cli_crd[c] > mem_pkg::CLI_DEPTH) begin
            $display("client %0d got more credits back than it spent", c);
            errors++;
          end
        end
        if (rsp_valid[c]) begin
          if (exp_q[c].size() == 0) begin
            $display("client %0d got a response it never asked for at %0t", c, $time);
            errors++;
          end else begin
            check_eq($sformatf("client %0d tag and data", c), {rsp_tag[c], rsp_rdata[c]},
                     exp_q[c].pop_front());
          end
        end
      end
      if (mem_req_valid) begin
        // round-robin over ports that always hold work
        check_eq("request client field", mem_req_id[mem_pkg::ID_W-1:mem_pkg::SEQ_W],
                 req_seen % NC);
        if (bus_q[req_seen % NC].size() == 0) begin
          $display("memory request at %0t with no pending client request", $time);
          errors++;
        end else begin
          check_eq("request tag and payload",
                   {mem_req_id[mem_pkg::SEQ_W-1:0], mem_req_we, mem_req_addr,
                    mem_req_wdata},
                   bus_q[req_seen % NC].pop_front());
        end
        req_seen++;
        mem_crd--;
        if (stall) begin
          stall_reqs++;
        end
      end
      if (mem_credit) begin
        mem_crd++;
      end
      if (mem_crd < 0) begin
        $display("memory request sent without a memory credit at %0t", $time);
        errors++;
      end
    end
  end

  // ----------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------
  initial begin
    seed = 32'ha62dfbf6;
    errors = 0;
    err_mark = 0;
    tests_run = 0;
    tests_failed = 0;
    mem_crd = mem_pkg::MEM_CREDITS;
    req_seen = 0;
    stall_reqs = 0;
    rst_n = 1'b0;
    stall = 1'b0;
    req_valid = '0;
    req_we = '0;
    for (int c = 0; c < NC; c++) begin
      req_addr[c] = '0;
      req_wdata[c] = '0;
      cli_crd[c] = mem_pkg::CLI_DEPTH;
      sent[c] = 0;
      pulses[c] = 0;
    end
    build_table();
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    check_eq("mem_req_valid after reset", mem_req_valid, 0);
    check_eq("cli_credit after reset", credit, 0);
    check_eq("cli_rsp_valid after reset", rsp_valid, 0);
    end_test("reset");

    for (int r = 0; r < 3; r++) begin
      drive_round(r);
    end
    wait_idle("unstalled traffic");
    end_test("traffic");

    // memory starts idle, so exactly its initial credits can go out
    stall = 1'b1;
    for (int r = 3; r < ROWS / NC; r++) begin
      drive_round(r);
    end
    repeat (20) @(negedge clk);
    check_eq("requests during stall", stall_reqs, mem_pkg::MEM_CREDITS);
    stall = 1'b0;
    wait_idle("traffic after stall release");
    end_test("credit stall");

    for (int c = 0; c < NC; c++) begin
      check_eq($sformatf("credit pulses of client %0d", c), pulses[c], sent[c]);
    end
    check_eq("memory requests", req_seen, ROWS);
    end_test("credit return");

    $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- src/client_port.sv
/*
 * Per-client request port: request buffer, ID tagging with a
 * running sequence number, outstanding-request limit, credit return
 * and response hand-off to the client.
 */

module client_port #(
  parameter int CLIENT_IDX = 0
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // client request side
  input  logic                        req_valid_i,
  input  logic                        req_we_i,
  input  logic [mem_pkg::ADDR_W-1:0]  req_addr_i,
  input  logic [mem_pkg::DATA_W-1:0]  req_wdata_i,
  output logic                        credit_o,
  // towards the arbiter
  input  logic                        grant_i,
  output logic                        port_valid_o,
  output mem_pkg::req_t               port_req_o,
  output logic [mem_pkg::ID_W-1:0]    port_id_o,
  // from the response router
  input  logic                        rsp_hit_i,
  input  logic [mem_pkg::SEQ_W-1:0]   rsp_tag_i,
  input  logic [mem_pkg::DATA_W-1:0]  rsp_rdata_i,
  // client response side
  output logic                        rsp_valid_o,
  output logic [mem_pkg::SEQ_W-1:0]   rsp_tag_o,
  output logic [mem_pkg::DATA_W-1:0]  rsp_rdata_o
);

  mem_pkg::req_t                 push_entry;
  logic                          fifo_empty;
  logic                          fifo_full;
  logic                          fifo_push;
  mem_pkg::seq_t                 seq_q;
  logic [mem_pkg::OUT_W-1:0]     out_cnt_q;
  logic                          credit_q;
  logic                          tags_free;

  // ----------------------------------------------------------
  // request buffer
  // ----------------------------------------------------------
  assign push_entry = '{we: req_we_i, addr: req_addr_i, wdata: req_wdata_i};

  // client holds a credit for every push, so full is only a guard
  assign fifo_push = req_valid_i && !fifo_full;

  sync_fifo #(
    .payload_t (mem_pkg::req_t),
    .DEPTH     (mem_pkg::CLI_DEPTH)
  ) i_req_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (fifo_push),
    .data_i  (push_entry),
    .pop_i   (grant_i),
    .data_o  (port_req_o),
    .empty_o (fifo_empty),
    .full_o  (fifo_full)
  );

  // ----------------------------------------------------------
  // tagging and outstanding limit
  // ----------------------------------------------------------
  // hold the head back once every sequence tag is in flight
  assign tags_free    = (out_cnt_q < mem_pkg::MAX_OUT);
  assign port_valid_o = !fifo_empty && tags_free;
  assign port_id_o    = {mem_pkg::cli_t'(CLIENT_IDX), seq_q};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      seq_q     <= '0;
      out_cnt_q <= '0;
      credit_q  <= 1'b0;
    end else begin
      // one credit back per entry leaving the buffer
      credit_q <= grant_i;
      if (grant_i) begin
        seq_q <= seq_q + 1'b1;
      end
      // grant and response in one cycle cancel out
      case ({grant_i, rsp_hit_i})
        2'b10:   out_cnt_q <= out_cnt_q + 1'b1;
        2'b01:   out_cnt_q <= out_cnt_q - 1'b1;
        default: out_cnt_q <= out_cnt_q;
      endcase
    end
  end

  assign credit_o = credit_q;

  // ----------------------------------------------------------
  // responses, always accepted by the client
  // ----------------------------------------------------------
  assign rsp_valid_o = rsp_hit_i;
  assign rsp_tag_o   = rsp_tag_i;
  assign rsp_rdata_o = rsp_rdata_i;

endmodule

//--- src/mem_pkg.sv
/*
 * Shared widths, counts and credit limits of the memory subsystem,
 * plus the request and response entry types.
 */

package mem_pkg;

  // ----------------------------------------------------------
  // sizes
  // ----------------------------------------------------------
  localparam int NUM_CLIENTS = 3;
  localparam int CLI_W       = 2;
  localparam int SEQ_W       = 2;
  localparam int ID_W        = CLI_W + SEQ_W;
  localparam int ADDR_W      = 16;
  localparam int DATA_W      = 32;

  // ----------------------------------------------------------
  // flow control
  // ----------------------------------------------------------
  // request buffer depth, also the client credits after reset
  localparam int CLI_DEPTH   = 4;
  // request slots granted by memory after reset
  localparam int MEM_CREDITS = 4;
  localparam int MEM_CRD_W   = $clog2(MEM_CREDITS + 1);
  // one sequence tag per outstanding request
  localparam int MAX_OUT     = 1 << SEQ_W;
  localparam int OUT_W       = SEQ_W + 1;

  typedef logic [CLI_W-1:0] cli_t;
  typedef logic [SEQ_W-1:0] seq_t;
  typedef logic [ID_W-1:0]  id_t;

  // single-beat request, 49 bits
  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } req_t;

  // response as it comes back from memory, 36 bits
  typedef struct packed {
    id_t               id;
    logic [DATA_W-1:0] rdata;
  } rsp_t;

endpackage

//--- src/mem_subsystem.sv
/*
 * Memory-side top level: response router, one request port per
 * client and the round-robin arbiter onto the memory bus.
 */

module mem_subsystem (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  // ----------------------------------------------------------
  // client side
  // ----------------------------------------------------------
  input  logic [mem_pkg::NUM_CLIENTS-1:0]   cli_req_valid_i,
  input  logic [mem_pkg::NUM_CLIENTS-1:0]   cli_req_we_i,
  input  logic [mem_pkg::ADDR_W-1:0]        cli_req_addr_i [mem_pkg::NUM_CLIENTS],
  input  logic [mem_pkg::DATA_W-1:0]        cli_req_wdata_i [mem_pkg::NUM_CLIENTS],
  output logic [mem_pkg::NUM_CLIENTS-1:0]   cli_credit_o,
  output logic [mem_pkg::NUM_CLIENTS-1:0]   cli_rsp_valid_o,
  output logic [mem_pkg::SEQ_W-1:0]         cli_rsp_tag_o [mem_pkg::NUM_CLIENTS],
  output logic [mem_pkg::DATA_W-1:0]        cli_rsp_rdata_o [mem_pkg::NUM_CLIENTS],
  // ----------------------------------------------------------
  // memory side
  // ----------------------------------------------------------
  output logic                              mem_req_valid_o,
  output logic                              mem_req_we_o,
  output logic [mem_pkg::ADDR_W-1:0]        mem_req_addr_o,
  output logic [mem_pkg::DATA_W-1:0]        mem_req_wdata_o,
  output logic [mem_pkg::ID_W-1:0]          mem_req_id_o,
  input  logic                              mem_credit_i,
  input  logic                              mem_rsp_valid_i,
  input  logic [mem_pkg::ID_W-1:0]          mem_rsp_id_i,
  input  logic [mem_pkg::DATA_W-1:0]        mem_rsp_rdata_i
);

  logic [mem_pkg::NUM_CLIENTS-1:0]  rsp_hit;
  logic [mem_pkg::SEQ_W-1:0]        rsp_tag;
  logic [mem_pkg::DATA_W-1:0]       rsp_rdata;
  logic [mem_pkg::NUM_CLIENTS-1:0]  port_valid;
  mem_pkg::req_t                    port_req [mem_pkg::NUM_CLIENTS];
  logic [mem_pkg::ID_W-1:0]         port_id [mem_pkg::NUM_CLIENTS];
  logic [mem_pkg::NUM_CLIENTS-1:0]  grant;

  resp_router i_resp_router (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_id_i    (mem_rsp_id_i),
    .mem_rsp_rdata_i (mem_rsp_rdata_i),
    .rsp_hit_o       (rsp_hit),
    .rsp_tag_o       (rsp_tag),
    .rsp_rdata_o     (rsp_rdata)
  );

  // one port per client, index doubles as the ID client field
  for (genvar c = 0; c < mem_pkg::NUM_CLIENTS; c++) begin : g_port
    client_port #(
      .CLIENT_IDX (c)
    ) i_client_port (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .req_valid_i  (cli_req_valid_i[c]),
      .req_we_i     (cli_req_we_i[c]),
      .req_addr_i   (cli_req_addr_i[c]),
      .req_wdata_i  (cli_req_wdata_i[c]),
      .credit_o     (cli_credit_o[c]),
      .grant_i      (grant[c]),
      .port_valid_o (port_valid[c]),
      .port_req_o   (port_req[c]),
      .port_id_o    (port_id[c]),
      .rsp_hit_i    (rsp_hit[c]),
      .rsp_tag_i    (rsp_tag),
      .rsp_rdata_i  (rsp_rdata),
      .rsp_valid_o  (cli_rsp_valid_o[c]),
      .rsp_tag_o    (cli_rsp_tag_o[c]),
      .rsp_rdata_o  (cli_rsp_rdata_o[c])
    );
  end

  req_arbiter i_req_arbiter (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .port_valid_i    (port_valid),
    .port_req_i      (port_req),
    .port_id_i       (port_id),
    .grant_o         (grant),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_we_o    (mem_req_we_o),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_req_wdata_o (mem_req_wdata_o),
    .mem_req_id_o    (mem_req_id_o),
    .mem_credit_i    (mem_credit_i)
  );

endmodule

//--- src/req_arbiter.sv
/*
 * Round-robin request arbiter. Picks one ready client port per cycle
 * while memory credits remain and registers it onto the memory bus.
 */

module req_arbiter (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic [mem_pkg::NUM_CLIENTS-1:0]    port_valid_i,
  input  mem_pkg::req_t                      port_req_i [mem_pkg::NUM_CLIENTS],
  input  logic [mem_pkg::ID_W-1:0]           port_id_i [mem_pkg::NUM_CLIENTS],
  output logic [mem_pkg::NUM_CLIENTS-1:0]    grant_o,
  output logic                               mem_req_valid_o,
  output logic                               mem_req_we_o,
  output logic [mem_pkg::ADDR_W-1:0]         mem_req_addr_o,
  output logic [mem_pkg::DATA_W-1:0]         mem_req_wdata_o,
  output logic [mem_pkg::ID_W-1:0]           mem_req_id_o,
  input  logic                               mem_credit_i
);

  mem_pkg::cli_t                   prio_q;
  mem_pkg::cli_t                   win_idx;
  logic                            send;
  logic [mem_pkg::MEM_CRD_W-1:0]   credit_cnt_q;

  // ----------------------------------------------------------
  // round-robin pick, search starts at prio_q
  // ----------------------------------------------------------
  always_comb begin
    int unsigned cand;
    send    = 1'b0;
    win_idx = '0;
    grant_o = '0;
    for (int i = 0; i < mem_pkg::NUM_CLIENTS; i++) begin
      cand = int'(prio_q) + i;
      if (cand >= mem_pkg::NUM_CLIENTS) begin
        cand = cand - mem_pkg::NUM_CLIENTS;
      end
      if (!send && port_valid_i[cand] && credit_cnt_q != '0) begin
        send    = 1'b1;
        win_idx = mem_pkg::cli_t'(cand);
      end
    end
    if (send) begin
      grant_o[win_idx] = 1'b1;
    end
  end

  // control state: pointer, credits, bus valid
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prio_q          <= '0;
      credit_cnt_q    <= mem_pkg::MEM_CRD_W'(mem_pkg::MEM_CREDITS);
      mem_req_valid_o <= 1'b0;
    end else begin
      mem_req_valid_o <= send;
      if (send) begin
        // next search begins right after the winner
        prio_q <= (win_idx == mem_pkg::NUM_CLIENTS - 1) ? '0 : win_idx + 1'b1;
      end
      case ({send, mem_credit_i})
        2'b10:   credit_cnt_q <= credit_cnt_q - 1'b1;
        2'b01:   credit_cnt_q <= credit_cnt_q + 1'b1;
        default: credit_cnt_q <= credit_cnt_q;
      endcase
    end
  end

  // bus payload, only meaningful with mem_req_valid_o
  always_ff @(posedge clk_i) begin
    if (send) begin
      mem_req_we_o    <= port_req_i[win_idx].we;
      mem_req_addr_o  <= port_req_i[win_idx].addr;
      mem_req_wdata_o <= port_req_i[win_idx].wdata;
      mem_req_id_o    <= port_id_i[win_idx];
    end
  end

endmodule

//--- src/resp_router.sv
/*
 * Response router: registers the memory response and decodes the
 * client field of its ID into a one-hot hit per client port.
 */

module resp_router (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              mem_rsp_valid_i,
  input  logic [mem_pkg::ID_W-1:0]          mem_rsp_id_i,
  input  logic [mem_pkg::DATA_W-1:0]        mem_rsp_rdata_i,
  output logic [mem_pkg::NUM_CLIENTS-1:0]   rsp_hit_o,
  output logic [mem_pkg::SEQ_W-1:0]         rsp_tag_o,
  output logic [mem_pkg::DATA_W-1:0]        rsp_rdata_o
);

  logic                        valid_q;
  mem_pkg::id_t                id_q;
  logic [mem_pkg::DATA_W-1:0]  rdata_q;
  mem_pkg::cli_t               cli_num;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= mem_rsp_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_rsp_valid_i) begin
      id_q    <= mem_rsp_id_i;
      rdata_q <= mem_rsp_rdata_i;
    end
  end

  // upper ID bits name the client, lower bits are its sequence tag
  assign cli_num = id_q[mem_pkg::ID_W-1:mem_pkg::SEQ_W];

  // unused client numbers fall through with no hit
  always_comb begin
    for (int c = 0; c < mem_pkg::NUM_CLIENTS; c++) begin
      rsp_hit_o[c] = valid_q && (cli_num == mem_pkg::cli_t'(c));
    end
  end

  assign rsp_tag_o   = id_q[mem_pkg::SEQ_W-1:0];
  assign rsp_rdata_o = rdata_q;

endmodule

//--- src/sync_fifo.sv
/*
 * Synchronous FIFO, payload type and depth set by parameters.
 * Registered storage, data pushed in one cycle is readable the next.
 */

module sync_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o,
  output logic     full_o
);

  payload_t                     mem_q [DEPTH];
  logic [$clog2(DEPTH)-1:0]     wr_ptr_q;
  logic [$clog2(DEPTH)-1:0]     rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0]   count_q;
  logic                         do_push;
  logic                         do_pop;

  // overflow and underflow attempts are dropped
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == DEPTH);
  assign data_o  = mem_q[rd_ptr_q];

  // storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // pointers and fill level
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule
